// ==== src.f ====
+incdir+common
common/serial_frame_pkg.sv
common/serial_ctrl_pkg.sv
rtl/clk_divider.sv
fifo/word_fifo.sv
rtl/frame_packer.sv
serial/serial_engine.sv
rtl/serial_bus_top.sv
tb/bus_device_model.sv
tb/tb_serial_bus.sv

// ==== Makefile ====
# Verilator build and run of the serial bus testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_serial_bus \
		-f src.f -Mdir obj_dir -o tb_serial_bus
	./obj_dir/tb_serial_bus > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/tb_serial_bus.sv ====
`default_nettype none

`include "serial_defs.svh"

module tb_serial_bus;

	localparam int TIMEOUT = 2000;
	// one serial period, the length of the gap after a frame
	localparam int GAP_CYCLES = 2 * `SERIAL_CLK_DIV;

	logic in_clk;
	logic in_rst;
	logic req_valid;
	logic req_ready;
	logic req_rw;
	logic [6:0] req_addr;
	logic [7:0] req_wdata;
	logic rd_valid;
	logic rd_ready;
	logic [7:0] rd_data;
	logic sclk;
	logic mosi;
	logic miso;
	logic timing_err;

	// reference registers and read data still owed in issue order
	logic [7:0] ref_regs [128];
	logic [7:0] exp_q [$];
	logic [7:0] exp_data;

	int seed;
	// rd_ready pattern
	// 0 keeps it high
	// 1 random
	// 2 held low
	int ready_mode;
	logic [31:0] ready_rnd;
	logic ready_next;
	string test_name;
	int test_errors;
	int total_errors;
	int tests_passed;
	int tests_failed;
	int reads_sent;
	int resp_seen;
	int idx;
	logic timed_out;

	serial_bus_top dut_i (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_rw(req_rw),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.rd_data(rd_data),
		.sclk(sclk),
		.mosi(mosi),
		.miso(miso)
	);

	bus_device_model dev_i (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.sclk(sclk),
		.mosi(mosi),
		.miso(miso),
		.timing_err(timing_err)
	);

	initial begin
		in_clk = 1'b0;
		forever #2 in_clk = ~in_clk;
	end

	// host side of the read port
	// pattern picked on the edge, applied one time unit later
	always @(posedge in_clk) begin
		ready_rnd = $random(seed);
		if (ready_mode == 1) begin
			ready_next = ready_rnd[0];
		end else begin
			ready_next = (ready_mode == 0);
		end
		#1;
		rd_ready = ready_next;
	end

	// every handshake pops one expected value
	always @(posedge in_clk) begin
		if (!in_rst && rd_valid && rd_ready) begin
			resp_seen++;
			if (exp_q.size() == 0) begin
				$display("unexpected read response %h in %s with no read pending", rd_data,
					test_name);
				test_errors++;
			end else begin
				exp_data = exp_q.pop_front();
				if (rd_data !== exp_data) begin
					$display("FAILED %s: expected %h, actual %h", test_name, exp_data, rd_data);
					test_errors++;
				end
			end
		end
		// bus timing violations flagged by the device
		if (timing_err) begin
			test_errors++;
		end
	end

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
		reads_sent = 0;
		resp_seen = 0;
	endtask

	task automatic end_test();
		total_errors += test_errors;
		if (test_errors == 0) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
		$display("test %s finished with %0d errors", test_name, test_errors);
	endtask

	// entered and left one time unit after a rising edge
	task automatic send_request(input logic rw, input logic [6:0] addr, input logic [7:0] wdata);
		int wait_cnt;
		if (timed_out) return;
		req_valid = 1'b1;
		req_rw = rw;
		req_addr = addr;
		req_wdata = wdata;
		wait_cnt = 0;
		@(posedge in_clk);
		while (!req_ready && (wait_cnt < TIMEOUT)) begin
			wait_cnt++;
			@(posedge in_clk);
		end
		if (!req_ready) begin
			$display("timeout: request never accepted in %s", test_name);
			timed_out = 1'b1;
			test_errors++;
		end else if (rw) begin
			exp_q.push_back(ref_regs[addr]);
			reads_sent++;
		end else begin
			ref_regs[addr] = wdata;
		end
		#1;
		req_valid = 1'b0;
	endtask

	task automatic drain_responses();
		int wait_cnt;
		if (timed_out) return;
		wait_cnt = 0;
		while ((exp_q.size() != 0) && (wait_cnt < TIMEOUT)) begin
			@(posedge in_clk);
			#1;
			wait_cnt++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d read responses missing in %s", exp_q.size(), test_name);
			timed_out = 1'b1;
			test_errors++;
		end else begin
			// a repeated response would arrive within the gap
			repeat (GAP_CYCLES) @(posedge in_clk);
			#1;
			if (resp_seen != reads_sent) begin
				$display("FAILED %s: expected %0d responses, actual %0d", test_name,
					reads_sent, resp_seen);
				test_errors++;
			end
		end
	endtask

	task automatic check_idle_levels();
		begin_test("idle_levels");
		repeat (40) begin
			@(posedge in_clk);
			if (sclk !== 1'b1) begin
				$display("FAILED idle_levels: sclk expected 1, actual %b", sclk);
				test_errors++;
			end
			if (mosi !== 1'b1) begin
				$display("FAILED idle_levels: mosi expected 1, actual %b", mosi);
				test_errors++;
			end
			if (rd_valid !== 1'b0) begin
				$display("FAILED idle_levels: rd_valid expected 0, actual %b", rd_valid);
				test_errors++;
			end
		end
		if (req_ready !== 1'b1) begin
			$display("FAILED idle_levels: req_ready expected 1, actual %b", req_ready);
			test_errors++;
		end
		#1;
		end_test();
	endtask

	task automatic read_reset_values();
		logic [31:0] rnd;
		begin_test("reset_values");
		repeat (8) begin
			rnd = $random(seed);
			send_request(1'b1, rnd[6:0], 8'h00);
		end
		drain_responses();
		end_test();
	endtask

	task automatic write_then_read();
		logic [31:0] rnd;
		begin_test("write_read");
		repeat (40) begin
			rnd = $random(seed);
			send_request(1'b0, rnd[6:0], rnd[15:8]);
			send_request(1'b1, rnd[6:0], 8'h00);
		end
		drain_responses();
		end_test();
	endtask

	task automatic mix_random_traffic();
		logic [31:0] rnd;
		begin_test("random_mix");
		ready_mode = 1;
		repeat (200) begin
			rnd = $random(seed);
			send_request(rnd[16], rnd[6:0], rnd[15:8]);
		end
		drain_responses();
		ready_mode = 0;
		end_test();
	endtask

	task automatic send_burst();
		logic [31:0] rnd;
		repeat (8) begin
			rnd = $random(seed);
			send_request(rnd[16], rnd[6:0], rnd[15:8]);
		end
	endtask

	// release the read port once the host side has stalled
	task automatic watch_for_stall();
		int wait_cnt;
		logic stall_seen;
		wait_cnt = 0;
		stall_seen = 1'b0;
		while (!stall_seen && (wait_cnt < TIMEOUT)) begin
			@(posedge in_clk);
			wait_cnt++;
			if (req_valid && !req_ready) begin
				stall_seen = 1'b1;
			end
		end
		if (!stall_seen) begin
			$display("req_ready never dropped during the burst in %s", test_name);
			test_errors++;
		end
		repeat (8) @(posedge in_clk);
		#1;
		ready_mode = 0;
	endtask

	task automatic burst_under_backpressure();
		begin_test("burst_backpressure");
		ready_mode = 2;
		@(posedge in_clk);
		#1;
		fork
			send_burst();
			watch_for_stall();
		join
		drain_responses();
		end_test();
	endtask

	initial begin
		seed = 32'h75d7af3a;
		in_rst = 1'b1;
		req_valid = 1'b0;
		req_rw = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		rd_ready = 1'b0;
		ready_mode = 0;
		timed_out = 1'b0;
		test_errors = 0;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		reads_sent = 0;
		resp_seen = 0;
		test_name = "reset";
		// device registers come up as the inverse of their address
		for (idx = 0; idx < 128; idx++) begin
			ref_regs[idx] = ~{1'b0, idx[6:0]};
		end
		repeat (16) @(posedge in_clk);
		#1;
		in_rst = 1'b0;
		check_idle_levels();
		if (!timed_out) read_reset_values();
		if (!timed_out) write_then_read();
		if (!timed_out) mix_random_traffic();
		if (!timed_out) burst_under_backpressure();
		$display("summary: %0d tests passed, %0d tests failed, %0d errors", tests_passed,
			tests_failed, total_errors);
		if ((total_errors == 0) && !timed_out) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/bus_device_model.sv ====
`default_nettype none

`include "serial_defs.svh"

module bus_device_model (
	input wire logic in_clk,
	input wire logic in_rst,
	input wire logic sclk,
	input wire logic mosi,
	output logic miso,
	output logic timing_err
);

	localparam int FRAME_BITS = `SERIAL_FRAME_BITS;
	localparam int DIV = `SERIAL_CLK_DIV;

	// register file, 7-bit address space
	logic [7:0] regs [128];
	logic sclk_q;
	logic [FRAME_BITS-1:0] shift_in;
	logic [FRAME_BITS-1:0] next_shift;
	logic cur_rw;
	logic [6:0] cur_addr;
	// rising edges seen in the current frame
	int bit_cnt;
	// in_clk cycles since the last sclk edge
	int since_edge;
	int idx;

	// sclk edges seen one in_clk cycle late, mosi is stable then
	always @(posedge in_clk) begin
		if (in_rst) begin
			for (idx = 0; idx < 128; idx++) begin
				regs[idx] <= ~{1'b0, idx[6:0]};
			end
			sclk_q <= 1'b1;
			miso <= 1'b1;
			timing_err <= 1'b0;
			shift_in <= '0;
			cur_rw <= 1'b0;
			cur_addr <= '0;
			bit_cnt <= 0;
			since_edge <= 255;
		end else begin
			timing_err <= 1'b0;
			sclk_q <= sclk;
			if (sclk != sclk_q) begin
				since_edge <= 1;
			end else if (since_edge < 255) begin
				since_edge <= since_edge + 1;
			end
			// rising sclk, take one mosi bit
			if (sclk && !sclk_q) begin
				if (since_edge < DIV) begin
					$display("device model error: rising sclk edge only %0d cycles after the last edge",
						since_edge);
					timing_err <= 1'b1;
				end
				next_shift = {shift_in[FRAME_BITS-2:0], mosi};
				shift_in <= next_shift;
				// rw and address complete after eight bits
				if (bit_cnt == 7) begin
					cur_rw <= next_shift[7];
					cur_addr <= next_shift[6:0];
				end
				if (bit_cnt == FRAME_BITS - 1) begin
					bit_cnt <= 0;
					// write frames land in the register
					if (!next_shift[FRAME_BITS-1]) begin
						regs[next_shift[14:8]] <= next_shift[7:0];
					end
				end else begin
					bit_cnt <= bit_cnt + 1;
				end
			end
			// falling sclk, next miso bit, data MSB first
			if (!sclk && sclk_q) begin
				if (cur_rw && (bit_cnt >= 8)) begin
					miso <= regs[cur_addr][FRAME_BITS-1-bit_cnt];
				end else begin
					miso <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/serial_bus_top.sv ====
`default_nettype none

`include "serial_defs.svh"

module serial_bus_top (
	input wire logic in_clk,
	input wire logic in_rst,

	// host request port
	input wire logic req_valid,
	output logic req_ready,
	input wire logic req_rw,
	input wire serial_frame_pkg::t_addr req_addr,
	input wire serial_frame_pkg::t_data req_wdata,

	// read response port
	output logic rd_valid,
	input wire logic rd_ready,
	output serial_frame_pkg::t_data rd_data,

	// three-wire bus
	output logic sclk,
	output logic mosi,
	input wire logic miso
);

	// packer to fifo
	logic pk_valid;
	logic pk_ready;
	serial_frame_pkg::t_frame pk_frame;

	// fifo to engine
	logic fq_valid;
	logic fq_ready;
	serial_frame_pkg::t_frame fq_frame;

	frame_packer packer_i (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_rw(req_rw),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.pk_valid(pk_valid),
		.pk_ready(pk_ready),
		.pk_frame(pk_frame)
	);

	// decouples the host from the slow bus
	word_fifo #(
		.DEPTH(`SERIAL_FIFO_DEPTH)
	) fifo_i (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.wr_valid(pk_valid),
		.wr_ready(pk_ready),
		.wr_frame(pk_frame),
		.rd_valid(fq_valid),
		.rd_ready(fq_ready),
		.rd_frame(fq_frame)
	);

	serial_engine engine_i (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.fq_valid(fq_valid),
		.fq_ready(fq_ready),
		.fq_frame(fq_frame),
		.sclk(sclk),
		.mosi(mosi),
		.miso(miso),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

// ==== serial/serial_engine.sv ====
`default_nettype none

`include "serial_defs.svh"

module serial_engine (
	input wire logic in_clk,
	input wire logic in_rst,

	// frames from the fifo
	input wire logic fq_valid,
	output logic fq_ready,
	input wire serial_frame_pkg::t_frame fq_frame,

	// three-wire bus
	output logic sclk,
	output logic mosi,
	input wire logic miso,

	// read responses
	output logic rd_valid,
	input wire logic rd_ready,
	output serial_frame_pkg::t_data rd_data
);

	localparam int FRAME_BITS = `SERIAL_FRAME_BITS;
	localparam int CNT_BITS = $clog2(FRAME_BITS);

	serial_ctrl_pkg::t_engine_state state;

	// rising ticks seen in this frame
	logic [CNT_BITS-1:0] bit_cnt;

	// transmit word, rotated so it is whole again after the frame
	serial_frame_pkg::t_frame tx_frame;
	// miso samples, MSB first
	serial_frame_pkg::t_frame rx_frame;

	logic run;
	logic rise_tick;
	logic fall_tick;
	logic last_bit;
	logic load;

	// divider only runs while the bus is busy
	assign run = (state == serial_ctrl_pkg::Shift) || (state == serial_ctrl_pkg::Gap);

	clk_divider clk_div_i (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.run(run),
		.rise_tick(rise_tick),
		.fall_tick(fall_tick)
	);

	// frames only taken while idle
	assign fq_ready = (state == serial_ctrl_pkg::Idle);
	assign load = fq_valid && fq_ready;

	// sixteenth rising tick ends the frame
	assign last_bit = rise_tick && (bit_cnt == CNT_BITS'(FRAME_BITS - 1));

	// control state and bus pins
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= serial_ctrl_pkg::Idle;
			bit_cnt <= '0;
			sclk <= 1'b1;
			mosi <= 1'b1;
		end else begin
			case (state)
				serial_ctrl_pkg::Idle: begin
					bit_cnt <= '0;
					if (load) begin
						state <= serial_ctrl_pkg::Shift;
					end
				end

				serial_ctrl_pkg::Shift: begin
					// new bit on the falling edge
					if (fall_tick) begin
						sclk <= 1'b0;
						mosi <= tx_frame.raw[FRAME_BITS-1];
					end
					// device samples on the rising edge
					if (rise_tick) begin
						sclk <= 1'b1;
						bit_cnt <= bit_cnt + 1'b1;
					end
					// rw decoded from the restored transmit word
					if (last_bit) begin
						if (tx_frame.f.rw) begin
							state <= serial_ctrl_pkg::Respond;
						end else begin
							state <= serial_ctrl_pkg::Gap;
						end
					end
				end

				serial_ctrl_pkg::Respond: begin
					if (rd_ready) begin
						state <= serial_ctrl_pkg::Gap;
					end
				end

				serial_ctrl_pkg::Gap: begin
					// data line back to idle level mid gap
					if (fall_tick) begin
						mosi <= 1'b1;
					end
					if (rise_tick) begin
						state <= serial_ctrl_pkg::Idle;
					end
				end

				default: begin
					state <= serial_ctrl_pkg::Idle;
				end
			endcase
		end
	end

	// shift registers, payload only
	always_ff @(posedge in_clk) begin
		if (load) begin
			tx_frame <= fq_frame;
		end else if ((state == serial_ctrl_pkg::Shift) && fall_tick) begin
			tx_frame.raw <= {tx_frame.raw[FRAME_BITS-2:0], tx_frame.raw[FRAME_BITS-1]};
		end
		if ((state == serial_ctrl_pkg::Shift) && rise_tick) begin
			rx_frame.raw <= {rx_frame.raw[FRAME_BITS-2:0], miso};
		end
	end

	// response is the data field of the received word
	assign rd_valid = (state == serial_ctrl_pkg::Respond);
	assign rd_data = rx_frame.f.data;

	// response held until the host takes it
	a_rd_stable: assert property (@(posedge in_clk) disable iff (in_rst)
		(rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_data)))
		else $error("serial_engine read data changed before handshake");

	// bus clock only toggles inside a frame
	a_sclk_idle: assert property (@(posedge in_clk) disable iff (in_rst)
		(state != serial_ctrl_pkg::Shift) |-> sclk)
		else $error("serial_engine sclk low outside shift");

endmodule

`default_nettype wire

// ==== rtl/frame_packer.sv ====
`default_nettype none

module frame_packer (
	input wire logic in_clk,
	input wire logic in_rst,

	// host requests
	input wire logic req_valid,
	output logic req_ready,
	input wire logic req_rw,
	input wire serial_frame_pkg::t_addr req_addr,
	input wire serial_frame_pkg::t_data req_wdata,

	// packed frames towards the fifo
	output logic pk_valid,
	input wire logic pk_ready,
	output serial_frame_pkg::t_frame pk_frame
);

	// output holding register
	logic hold_valid;
	serial_frame_pkg::t_frame hold_frame;
	// goes high the cycle after reset release
	logic ready_en;
	logic accept;

	// free slot, or the current frame leaves this cycle
	assign req_ready = ready_en && (!hold_valid || pk_ready);
	assign accept = req_valid && req_ready;

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			ready_en <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			ready_en <= 1'b1;
			// refill or drain only when the slot moves
			if (!hold_valid || pk_ready) begin
				hold_valid <= accept;
			end
		end
	end

	// build the frame by fields
	always_ff @(posedge in_clk) begin
		if (accept) begin
			hold_frame.f.rw <= req_rw;
			hold_frame.f.addr <= req_addr;
			// reads carry zeros, the device answers in that slot
			hold_frame.f.data <= req_rw ? '0 : req_wdata;
		end
	end

	assign pk_valid = hold_valid;
	assign pk_frame = hold_frame;

endmodule

`default_nettype wire

// ==== fifo/word_fifo.sv ====
`default_nettype none

module word_fifo #(
	// number of entries, a power of two of at least 2
	parameter int DEPTH = 4
) (
	input wire logic in_clk,
	input wire logic in_rst,

	// write side from the packer
	input wire logic wr_valid,
	output logic wr_ready,
	input wire serial_frame_pkg::t_frame wr_frame,

	// read side towards the engine
	output logic rd_valid,
	input wire logic rd_ready,
	output serial_frame_pkg::t_frame rd_frame
);

	localparam int ADDR_BITS = $clog2(DEPTH);

	// depth check at elaboration
	if ((DEPTH < 2) || ((DEPTH & (DEPTH - 1)) != 0)) begin : g_depth_check
		$error("word_fifo DEPTH must be a power of two of at least 2");
	end

	// frame storage
	serial_frame_pkg::t_frame mem [DEPTH];

	// pointers with extra wrap bit
	logic [ADDR_BITS:0] wr_ptr;
	logic [ADDR_BITS:0] rd_ptr;
	logic [ADDR_BITS:0] count;
	logic full;
	logic empty;
	logic push;
	logic pop;

	// same index on the other lap
	assign full = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS]) &&
		(wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);
	assign empty = (wr_ptr == rd_ptr);
	assign count = wr_ptr - rd_ptr;

	assign wr_ready = !full;
	assign rd_valid = !empty;
	// head entry shown directly
	assign rd_frame = mem[rd_ptr[ADDR_BITS-1:0]];

	assign push = wr_valid && wr_ready;
	assign pop = rd_valid && rd_ready;

	always_ff @(posedge in_clk) begin
		if (push) begin
			mem[wr_ptr[ADDR_BITS-1:0]] <= wr_frame;
		end
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// fill level stays in range
	// an underflow would wrap above DEPTH as well
	a_count_range: assert property (@(posedge in_clk) disable iff (in_rst)
		count <= DEPTH)
		else $error("word_fifo fill level out of range: %0d", count);

endmodule

`default_nettype wire

// ==== rtl/clk_divider.sv ====
`default_nettype none

`include "serial_defs.svh"

module clk_divider (
	input wire logic in_clk,
	input wire logic in_rst,
	input wire logic run,
	output logic rise_tick,
	output logic fall_tick
);

	localparam int DIV = `SERIAL_CLK_DIV;
	localparam int CNT_BITS = (DIV > 1) ? $clog2(DIV) : 1;

	// cycles within the current half period
	logic [CNT_BITS-1:0] cnt;
	// low before a fall tick, high before a rise tick
	logic phase;
	logic wrap;

	// end of a half period
	assign wrap = run && (cnt == CNT_BITS'(DIV - 1));

	always_ff @(posedge in_clk) begin
		if (in_rst || !run) begin
			// idle keeps the phase aligned to the next frame
			cnt <= '0;
			phase <= 1'b0;
		end else if (wrap) begin
			cnt <= '0;
			phase <= ~phase;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// first tick after run is always a fall
	assign fall_tick = wrap && !phase;
	assign rise_tick = wrap && phase;

endmodule

`default_nettype wire

// ==== common/serial_ctrl_pkg.sv ====
`default_nettype none

package serial_ctrl_pkg;

	// engine states
	typedef enum logic [1:0] {
		// waiting for a frame from the fifo
		Idle,
		// clocking the frame out, miso captured
		Shift,
		// read data offered to the host
		Respond,
		// one idle serial period between frames
		Gap
	} t_engine_state;

endpackage

`default_nettype wire

// ==== common/serial_frame_pkg.sv ====
`default_nettype none

`include "serial_defs.svh"

package serial_frame_pkg;

	// register address on the bus
	typedef logic [6:0] t_addr;

	// register data byte
	typedef logic [7:0] t_data;

	// one bus frame
	// raw view for shifting, field view for building and decoding
	typedef union packed {
		logic [`SERIAL_FRAME_BITS-1:0] raw;
		struct packed {
			logic rw;     // 1 means read
			t_addr addr;
			t_data data;  // zero on reads, returned on miso
		} f;
	} t_frame;

endpackage

`default_nettype wire

// ==== common/serial_defs.svh ====
`ifndef SERIAL_DEFS_SVH
`define SERIAL_DEFS_SVH

// bits in one bus frame
// rw flag, address and data, MSB first on the wire
`define SERIAL_FRAME_BITS 16

// in_clk cycles per serial half period
// a full serial period is twice this
`define SERIAL_CLK_DIV 4

// frames buffered between packer and engine
// must stay a power of two
`define SERIAL_FIFO_DEPTH 4

`endif
